//--- build.f
design/fifo_geom_pkg.sv
design/fifo_bus_pkg.sv
design/fifo_write_port.sv
design/fifo_read_port.sv
design/fifo_level_tracker.sv
design/fifo_sync_ctrl.sv
verification/fifo_sync_ctrl_props.sv
verification/fifo_checker.sv
verification/fifo_sync_ctrl_tb.sv

//--- verification/fifo_vectors.txt
# test wr_en rd_en | full afull empty aempty level wack dvld overflow underflow waddr raddr
# columns after the bar are the registered outputs one cycle after the inputs are sampled
1 0 0 0 0 1 1 0 0 0 0 0 0 0
1 0 0 0 0 1 1 0 0 0 0 0 0 0
2 1 0 0 0 0 1 1 1 0 0 0 1 0
2 1 0 0 0 0 1 2 1 0 0 0 2 0
2 1 0 0 0 0 1 3 1 0 0 0 3 0
2 1 0 0 0 0 1 4 1 0 0 0 4 0
2 1 0 0 0 0 0 5 1 0 0 0 5 0
2 1 0 0 0 0 0 6 1 0 0 0 6 0
2 1 0 0 0 0 0 7 1 0 0 0 7 0
2 1 0 0 0 0 0 8 1 0 0 0 8 0
2 1 0 0 0 0 0 9 1 0 0 0 9 0
2 1 0 0 0 0 0 10 1 0 0 0 10 0
2 1 0 0 0 0 0 11 1 0 0 0 11 0
2 1 0 0 0 0 0 12 1 0 0 0 12 0
2 1 0 0 0 0 0 13 1 0 0 0 13 0
2 1 0 0 1 0 0 14 1 0 0 0 14 0
2 1 0 0 1 0 0 15 1 0 0 0 15 0
2 1 0 1 1 0 0 16 1 0 0 0 0 0
2 1 0 1 1 0 0 16 0 0 1 0 0 0
3 0 1 0 1 0 0 15 0 1 0 0 0 1
3 0 1 0 1 0 0 14 0 1 0 0 0 2
3 0 1 0 0 0 0 13 0 1 0 0 0 3
3 0 1 0 0 0 0 12 0 1 0 0 0 4
3 0 1 0 0 0 0 11 0 1 0 0 0 5
3 0 1 0 0 0 0 10 0 1 0 0 0 6
3 0 1 0 0 0 0 9 0 1 0 0 0 7
3 0 1 0 0 0 0 8 0 1 0 0 0 8
3 0 1 0 0 0 0 7 0 1 0 0 0 9
3 0 1 0 0 0 0 6 0 1 0 0 0 10
3 0 1 0 0 0 0 5 0 1 0 0 0 11
3 0 1 0 0 0 1 4 0 1 0 0 0 12
3 0 1 0 0 0 1 3 0 1 0 0 0 13
3 0 1 0 0 0 1 2 0 1 0 0 0 14
3 0 1 0 0 0 1 1 0 1 0 0 0 15
3 0 1 0 0 1 1 0 0 1 0 0 0 0
3 0 1 0 0 1 1 0 0 0 0 1 0 0
4 1 0 0 0 0 1 1 1 0 0 0 1 0
4 1 0 0 0 0 1 2 1 0 0 0 2 0
4 1 0 0 0 0 1 3 1 0 0 0 3 0
4 1 0 0 0 0 1 4 1 0 0 0 4 0
4 1 0 0 0 0 0 5 1 0 0 0 5 0
4 1 0 0 0 0 0 6 1 0 0 0 6 0
4 1 0 0 0 0 0 7 1 0 0 0 7 0
4 1 0 0 0 0 0 8 1 0 0 0 8 0
4 1 1 0 0 0 0 8 1 1 0 0 9 1
4 1 1 0 0 0 0 8 1 1 0 0 10 2
4 1 1 0 0 0 0 8 1 1 0 0 11 3
5 1 1 0 0 0 0 8 1 1 0 0 12 4
5 1 1 0 0 0 0 8 1 1 0 0 13 5
5 1 1 0 0 0 0 8 1 1 0 0 14 6
5 1 1 0 0 0 0 8 1 1 0 0 15 7
5 1 1 0 0 0 0 8 1 1 0 0 0 8
5 0 1 0 0 0 0 7 0 1 0 0 0 9
5 0 1 0 0 0 0 6 0 1 0 0 0 10
5 0 1 0 0 0 0 5 0 1 0 0 0 11
5 0 1 0 0 0 1 4 0 1 0 0 0 12
5 0 1 0 0 0 1 3 0 1 0 0 0 13
5 0 1 0 0 0 1 2 0 1 0 0 0 14
5 0 1 0 0 0 1 1 0 1 0 0 0 15
5 0 1 0 0 1 1 0 0 1 0 0 0 0

//--- verification/fifo_sync_ctrl_tb.sv
/*
 * Testbench for the FIFO controller.
 * Reads per-cycle stimulus and expected outputs from the vectors
 * file, drives the DUT after reset and hands the expected values to
 * the checker. A cycle counter bounds the run.
 */

`timescale 1ns/100ps

module fifo_sync_ctrl_tb;

   logic pos_clk;
   logic aresetn;
   logic wr_en;
   logic rd_en;

   fifo_bus_pkg::mem_wr_t      mem_wr;
   fifo_bus_pkg::mem_rd_t      mem_rd;
   fifo_bus_pkg::fifo_status_t status;
   logic                       wack;
   logic                       dvld;
   logic                       overflow;
   logic                       underflow;

   // expected values toward the checker
   logic                       exp_valid;
   int                         exp_test;
   fifo_bus_pkg::fifo_status_t exp_status;
   logic [3:0]                 exp_pulse;
   fifo_geom_pkg::mem_addr_t   exp_waddr;
   fifo_geom_pkg::mem_addr_t   exp_raddr;

   logic chk_done;
   int   chk_checks;
   int   chk_errors;
   int   chk_tests;

   // vectors as loaded, one entry per cycle
   int                         test_q[$];
   logic [1:0]                 stim_q[$];
   fifo_bus_pkg::fifo_status_t status_q[$];
   logic [3:0]                 pulse_q[$];
   fifo_geom_pkg::mem_addr_t   waddr_q[$];
   fifo_geom_pkg::mem_addr_t   raddr_q[$];

   logic load_ok = 1'b0;
   int   cycle_count = 0;
   int   cycle_limit = 0;
   int   idx;

   // ------------------------------------------------------------
   // DUT, checker and bound assertions
   // ------------------------------------------------------------

   fifo_sync_ctrl fifo_sync_ctrl_inst (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en),
      .rd_en_i     (rd_en),
      .mem_wr_o    (mem_wr),
      .mem_rd_o    (mem_rd),
      .status_o    (status),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (overflow),
      .underflow_o (underflow)
   );

   fifo_checker u_checker (
      .pos_clk      (pos_clk),
      .status_i     (status),
      .mem_wr_i     (mem_wr),
      .mem_rd_i     (mem_rd),
      .wack_i       (wack),
      .dvld_i       (dvld),
      .overflow_i   (overflow),
      .underflow_i  (underflow),
      .exp_valid_i  (exp_valid),
      .exp_test_i   (exp_test),
      .exp_status_i (exp_status),
      .exp_pulse_i  (exp_pulse),
      .exp_waddr_i  (exp_waddr),
      .exp_raddr_i  (exp_raddr),
      .done_o       (chk_done),
      .checks_o     (chk_checks),
      .errors_o     (chk_errors),
      .tests_o      (chk_tests)
   );

   bind fifo_sync_ctrl fifo_sync_ctrl_props u_props (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .status_i   (status_o),
      .mem_wr_i   (mem_wr_o),
      .mem_rd_i   (mem_rd_o),
      .overflow_i (overflow_o)
   );

   // ------------------------------------------------------------
   // vector file
   // ------------------------------------------------------------

   // comment and blank lines fail the scan and are skipped
   task automatic load_vectors();
      int    fd;
      int    n;
      string line;
      int    t, wr, rd, f, af, e, ae, lv, wk, dv, ov, ud, wa, ra;
      fifo_bus_pkg::fifo_status_t st;
      fd = $fopen("verification/fifo_vectors.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
               n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                           t, wr, rd, f, af, e, ae, lv, wk, dv, ov, ud, wa, ra);
               if (n == 14) begin
                  st.full   = f[0];
                  st.afull  = af[0];
                  st.empty  = e[0];
                  st.aempty = ae[0];
                  st.level  = fifo_geom_pkg::level_t'(lv);
                  test_q.push_back(t);
                  stim_q.push_back({wr[0], rd[0]});
                  status_q.push_back(st);
                  pulse_q.push_back({wk[0], dv[0], ov[0], ud[0]});
                  waddr_q.push_back(fifo_geom_pkg::mem_addr_t'(wa));
                  raddr_q.push_back(fifo_geom_pkg::mem_addr_t'(ra));
               end
            end
         end
         $fclose(fd);
      end
      load_ok = (test_q.size() > 0);
   endtask

   // ------------------------------------------------------------
   // clock and timeout
   // ------------------------------------------------------------

   initial begin
      pos_clk = 1'b0;
      forever #5 pos_clk = ~pos_clk;
   end

   always @(posedge pos_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // reset, stimulus and result
   // ------------------------------------------------------------

   initial begin
      aresetn    = 1'b0;
      wr_en      = 1'b0;
      rd_en      = 1'b0;
      exp_valid  = 1'b0;
      exp_test   = 0;
      exp_status = '0;
      exp_pulse  = '0;
      exp_waddr  = '0;
      exp_raddr  = '0;
      load_vectors();
      if (!load_ok) begin
         $display("could not read any vectors from verification/fifo_vectors.txt");
         $display("TEST FAILED");
         $finish;
      end
      else begin
         // vectors, reset and some slack for the checker pipeline
         cycle_limit = test_q.size() + 16 + 20;
         repeat (16) @(posedge pos_clk);
         aresetn <= 1'b1;
         for (idx = 0; idx < test_q.size(); idx++) begin
            @(posedge pos_clk);
            {wr_en, rd_en} <= stim_q[idx];
            exp_valid      <= 1'b1;
            exp_test       <= test_q[idx];
            exp_status     <= status_q[idx];
            exp_pulse      <= pulse_q[idx];
            exp_waddr      <= waddr_q[idx];
            exp_raddr      <= raddr_q[idx];
         end
         @(posedge pos_clk);
         wr_en     <= 1'b0;
         rd_en     <= 1'b0;
         exp_valid <= 1'b0;
         wait (chk_done);
         $display("summary: %0d tests, %0d cycles checked, %0d mismatches, %0d assertion failures",
                  chk_tests, chk_checks, chk_errors, fifo_sync_ctrl_inst.u_props.fail_count);
         if (chk_errors == 0 && chk_checks == test_q.size() &&
             fifo_sync_ctrl_inst.u_props.fail_count == 0) begin
            $display("TEST OK");
         end
         else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

//--- verification/fifo_checker.sv
/*
 * Checker for the FIFO controller testbench.
 * Takes one expected vector per cycle, holds it for a cycle while
 * the DUT registers respond, then compares at the following edge.
 * Prints a line per finished test and exposes the counts.
 */

`timescale 1ns/100ps

module fifo_checker (
   input  logic                       pos_clk,
   input  fifo_bus_pkg::fifo_status_t status_i,
   input  fifo_bus_pkg::mem_wr_t      mem_wr_i,
   input  fifo_bus_pkg::mem_rd_t      mem_rd_i,
   input  logic                       wack_i,
   input  logic                       dvld_i,
   input  logic                       overflow_i,
   input  logic                       underflow_i,
   input  logic                       exp_valid_i,
   input  int                         exp_test_i,
   input  fifo_bus_pkg::fifo_status_t exp_status_i,
   // wack, dvld, overflow, underflow
   input  logic [3:0]                 exp_pulse_i,
   input  fifo_geom_pkg::mem_addr_t   exp_waddr_i,
   input  fifo_geom_pkg::mem_addr_t   exp_raddr_i,
   output logic                       done_o,
   output int                         checks_o,
   output int                         errors_o,
   output int                         tests_o
);

   // vector waiting for the DUT to respond
   logic                       pend_valid = 1'b0;
   int                         pend_test  = 0;
   fifo_bus_pkg::fifo_status_t pend_status;
   logic [3:0]                 pend_pulse;
   fifo_geom_pkg::mem_addr_t   pend_waddr;
   fifo_geom_pkg::mem_addr_t   pend_raddr;

   // RAM strobes as seen at the sampling edge
   // they match the accept, so wack and dvld of the same vector
   logic                       seen_we = 1'b0;
   logic                       seen_re = 1'b0;

   logic done = 1'b0;
   int   checks = 0;
   int   errors = 0;
   int   tests = 0;
   // per test
   int   test_checks = 0;
   int   test_errors = 0;

   // one field, one line on a difference
   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%0h, expected 0x%0h (test %0d)",
                  name, got, exp, pend_test);
         errors++;
         test_errors++;
      end
   endtask

   // ------------------------------------------------------------
   // compare and pipeline
   // ------------------------------------------------------------

   always @(posedge pos_clk) begin
      if (pend_valid) begin
         compare_field("status_o.full", status_i.full, pend_status.full);
         compare_field("status_o.afull", status_i.afull, pend_status.afull);
         compare_field("status_o.empty", status_i.empty, pend_status.empty);
         compare_field("status_o.aempty", status_i.aempty, pend_status.aempty);
         compare_field("status_o.level", status_i.level, pend_status.level);
         compare_field("wack_o", wack_i, pend_pulse[3]);
         compare_field("dvld_o", dvld_i, pend_pulse[2]);
         compare_field("overflow_o", overflow_i, pend_pulse[1]);
         compare_field("underflow_o", underflow_i, pend_pulse[0]);
         compare_field("mem_wr_o.addr", mem_wr_i.addr, pend_waddr);
         compare_field("mem_rd_o.addr", mem_rd_i.addr, pend_raddr);
         compare_field("mem_wr_o.we", seen_we, pend_pulse[3]);
         compare_field("mem_rd_o.re", seen_re, pend_pulse[2]);
         checks++;
         test_checks++;
         // next vector belongs elsewhere, so this test is over
         if (!exp_valid_i || exp_test_i != pend_test) begin
            $display("test %0d %s: %0d cycles, %0d errors", pend_test,
                     (test_errors == 0) ? "passed" : "has errors", test_checks, test_errors);
            tests++;
            test_checks = 0;
            test_errors = 0;
            if (!exp_valid_i) begin
               done <= 1'b1;
            end
         end
      end
      pend_valid  <= exp_valid_i;
      pend_test   <= exp_test_i;
      pend_status <= exp_status_i;
      pend_pulse  <= exp_pulse_i;
      pend_waddr  <= exp_waddr_i;
      pend_raddr  <= exp_raddr_i;
      seen_we     <= mem_wr_i.we;
      seen_re     <= mem_rd_i.re;
   end

   assign done_o   = done;
   assign checks_o = checks;
   assign errors_o = errors;
   assign tests_o  = tests;

endmodule

//--- verification/fifo_sync_ctrl_props.sv
/*
 * Protocol invariants of the FIFO controller.
 * Bound into fifo_sync_ctrl from the testbench, watches the status
 * bundle, the RAM strobes and the overflow pulse.
 */

`timescale 1ns/100ps

module fifo_sync_ctrl_props (
   input logic                       pos_clk,
   input logic                       aresetn,
   input fifo_bus_pkg::fifo_status_t status_i,
   input fifo_bus_pkg::mem_wr_t      mem_wr_i,
   input fifo_bus_pkg::mem_rd_t      mem_rd_i,
   input logic                       overflow_i
);

   // failed assertion count
   int fail_count = 0;

   // ------------------------------------------------------------
   // flag consistency
   // ------------------------------------------------------------

   // level cannot be 0 and FIFO_DEPTH at once
   full_empty_excl: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(status_i.full && status_i.empty))
      else begin
         $error("full and empty are high in the same cycle");
         fail_count++;
      end

   // ------------------------------------------------------------
   // strobes against back-pressure
   // ------------------------------------------------------------

   // no RAM write into a full FIFO
   no_write_when_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_wr_i.we |-> !status_i.full)
      else begin
         $error("RAM write strobe high while full");
         fail_count++;
      end

   // no RAM read from an empty FIFO
   no_read_when_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_rd_i.re |-> !status_i.empty)
      else begin
         $error("RAM read strobe high while empty");
         fail_count++;
      end

   // overflow is one cycle behind a refused write
   overflow_after_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      overflow_i |-> $past(status_i.full))
      else begin
         $error("overflow without full in the previous cycle");
         fail_count++;
      end

endmodule

//--- design/fifo_sync_ctrl.sv
/*
 * Top level of the single-clock FIFO controller.
 * Holds no data, only drives the address and strobes of an external
 * RAM and reports the registered status and handshake pulses.
 */

`timescale 1ns/100ps

module fifo_sync_ctrl (
   input  logic                       pos_clk,
   input  logic                       aresetn,
   input  logic                       wr_en_i,
   input  logic                       rd_en_i,
   output fifo_bus_pkg::mem_wr_t      mem_wr_o,
   output fifo_bus_pkg::mem_rd_t      mem_rd_o,
   output fifo_bus_pkg::fifo_status_t status_o,
   output logic                       wack_o,
   output logic                       dvld_o,
   output logic                       overflow_o,
   output logic                       underflow_o
);

   // accept pulses into the tracker
   logic wr_accept;
   logic rd_accept;

   // write side, back-pressured by full
   fifo_write_port u_write_port (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .full_i      (status_o.full),
      .wr_accept_o (wr_accept),
      .mem_wr_o    (mem_wr_o),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o)
   );

   // read side, back-pressured by empty
   fifo_read_port u_read_port (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .rd_en_i     (rd_en_i),
      .empty_i     (status_o.empty),
      .rd_accept_o (rd_accept),
      .mem_rd_o    (mem_rd_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   // level and flags
   fifo_level_tracker u_level_tracker (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .status_o    (status_o)
   );

endmodule

//--- design/fifo_level_tracker.sv
/*
 * Occupancy tracking for the FIFO controller.
 * Counts entries from the write and read accept pulses and registers
 * full, almost-full, empty and almost-empty from the next level.
 * Only place where full and empty are decided.
 */

`timescale 1ns/100ps

module fifo_level_tracker (
   input  logic                       pos_clk,
   input  logic                       aresetn,
   input  logic                       wr_accept_i,
   input  logic                       rd_accept_i,
   output fifo_bus_pkg::fifo_status_t status_o
);

   fifo_geom_pkg::level_t level_q;
   fifo_geom_pkg::level_t level_nxt;

   logic full_q;
   logic afull_q;
   logic empty_q;
   logic aempty_q;

   // flags as seen from the next level
   logic full_nxt;
   logic afull_nxt;
   logic empty_nxt;
   logic aempty_nxt;

   // ------------------------------------------------------------
   // next level
   // ------------------------------------------------------------

   // accepts never push past 0 or FIFO_DEPTH,
   // the ports already gate on full and empty
   always_comb begin
      case ({wr_accept_i, rd_accept_i})
         2'b10:   level_nxt = level_q + fifo_geom_pkg::level_t'(1);
         2'b01:   level_nxt = level_q - fifo_geom_pkg::level_t'(1);
         // both or neither leave the count alone
         default: level_nxt = level_q;
      endcase
   end

   // ------------------------------------------------------------
   // flag compares
   // ------------------------------------------------------------

   // plain threshold compares, no hysteresis
   assign full_nxt   = (level_nxt == fifo_geom_pkg::level_t'(fifo_geom_pkg::FIFO_DEPTH));
   assign empty_nxt  = (level_nxt == '0);
   assign afull_nxt  = (level_nxt >= fifo_geom_pkg::level_t'(fifo_geom_pkg::AFULL_LEVEL));
   assign aempty_nxt = (level_nxt <= fifo_geom_pkg::level_t'(fifo_geom_pkg::AEMPTY_LEVEL));

   // ------------------------------------------------------------
   // registers
   // ------------------------------------------------------------

   // reset to an empty FIFO
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_q  <= '0;
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;
         aempty_q <= 1'b1;
      end
      else begin
         level_q  <= level_nxt;
         full_q   <= full_nxt;
         afull_q  <= afull_nxt;
         empty_q  <= empty_nxt;
         aempty_q <= aempty_nxt;
      end
   end

   // ------------------------------------------------------------
   // status bundle
   // ------------------------------------------------------------

   // full and empty here feed back to the ports as back-pressure
   assign status_o.full   = full_q;
   assign status_o.afull  = afull_q;
   assign status_o.empty  = empty_q;
   assign status_o.aempty = aempty_q;
   assign status_o.level  = level_q;

endmodule

//--- design/fifo_read_port.sv
/*
 * Read side of the FIFO controller.
 * Accepts a read while the registered empty flag is low, drives the
 * RAM read strobe in the same cycle and steps the wrapping read
 * address. Data-valid and underflow come one cycle later.
 */

`timescale 1ns/100ps

module fifo_read_port (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  rd_en_i,
   input  logic                  empty_i,
   output logic                  rd_accept_o,
   output fifo_bus_pkg::mem_rd_t mem_rd_o,
   output logic                  dvld_o,
   output logic                  underflow_o
);

   // current read slot
   fifo_geom_pkg::mem_addr_t rd_addr_q;
   // slot after the current one, wrapped
   fifo_geom_pkg::mem_addr_t rd_addr_nxt;
   logic                     rd_accept;
   logic                     dvld_q;
   logic                     underflow_q;

   // ------------------------------------------------------------
   // accept
   // ------------------------------------------------------------

   // stop on empty, a refused read is dropped
   assign rd_accept = rd_en_i & ~empty_i;

   assign rd_accept_o = rd_accept;

   // RAM strobe is combinational, same cycle as the accept
   assign mem_rd_o.addr = rd_addr_q;
   assign mem_rd_o.re   = rd_accept;

   // ------------------------------------------------------------
   // read address
   // ------------------------------------------------------------

   // wrap at the last slot
   always_comb begin
      if (rd_addr_q == fifo_geom_pkg::mem_addr_t'(fifo_geom_pkg::FIFO_DEPTH - 1)) begin
         rd_addr_nxt = '0;
      end
      else begin
         rd_addr_nxt = rd_addr_q + fifo_geom_pkg::mem_addr_t'(1);
      end
   end

   // step only on an accepted read
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_addr_q <= '0;
      end
      else if (rd_accept) begin
         rd_addr_q <= rd_addr_nxt;
      end
   end

   // ------------------------------------------------------------
   // data-valid and underflow
   // ------------------------------------------------------------

   // RAM read is registered, so dvld lines up with its output
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_q      <= 1'b0;
         underflow_q <= 1'b0;
      end
      else begin
         dvld_q      <= rd_accept;
         // read asked for while empty
         underflow_q <= rd_en_i & empty_i;
      end
   end

   assign dvld_o      = dvld_q;
   assign underflow_o = underflow_q;

endmodule

//--- design/fifo_write_port.sv
/*
 * Write side of the FIFO controller.
 * Accepts a write while the registered full flag is low, drives the
 * RAM write strobe in the same cycle and steps the wrapping write
 * address. Write acknowledge and overflow come one cycle later.
 */

`timescale 1ns/100ps

module fifo_write_port (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_en_i,
   input  logic                  full_i,
   output logic                  wr_accept_o,
   output fifo_bus_pkg::mem_wr_t mem_wr_o,
   output logic                  wack_o,
   output logic                  overflow_o
);

   // current write slot
   fifo_geom_pkg::mem_addr_t wr_addr_q;
   // slot after the current one, wrapped
   fifo_geom_pkg::mem_addr_t wr_addr_nxt;
   logic                     wr_accept;
   logic                     wack_q;
   logic                     overflow_q;

   // ------------------------------------------------------------
   // accept
   // ------------------------------------------------------------

   // stop on full, a refused write is dropped
   assign wr_accept = wr_en_i & ~full_i;

   assign wr_accept_o = wr_accept;

   // RAM strobe is combinational, same cycle as the accept
   assign mem_wr_o.addr = wr_addr_q;
   assign mem_wr_o.we   = wr_accept;

   // ------------------------------------------------------------
   // write address
   // ------------------------------------------------------------

   // wrap at the last slot, depth need not be a power of two
   always_comb begin
      if (wr_addr_q == fifo_geom_pkg::mem_addr_t'(fifo_geom_pkg::FIFO_DEPTH - 1)) begin
         wr_addr_nxt = '0;
      end
      else begin
         wr_addr_nxt = wr_addr_q + fifo_geom_pkg::mem_addr_t'(1);
      end
   end

   // step only on an accepted write
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_addr_q <= '0;
      end
      else if (wr_accept) begin
         wr_addr_q <= wr_addr_nxt;
      end
   end

   // ------------------------------------------------------------
   // acknowledge and overflow
   // ------------------------------------------------------------

   // single-cycle pulses, one cycle behind the sampling edge
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_q     <= 1'b0;
         overflow_q <= 1'b0;
      end
      else begin
         wack_q     <= wr_accept;
         // write asked for while full
         overflow_q <= wr_en_i & full_i;
      end
   end

   assign wack_o     = wack_q;
   assign overflow_o = overflow_q;

endmodule

//--- design/fifo_bus_pkg.sv
/*
 * Bundles that leave the FIFO controller.
 * Write and read ports toward the external RAM, and the registered
 * status word. Widths come from the geometry package.
 */

package fifo_bus_pkg;

   // ------------------------------------------------------------
   // RAM ports
   // ------------------------------------------------------------

   // write side of the external RAM
   // addr is the slot written while we is high
   typedef struct packed {
      fifo_geom_pkg::mem_addr_t addr;
      logic                     we;
   } mem_wr_t;

   // read side of the external RAM
   // RAM registers the read, data valid one cycle after re
   typedef struct packed {
      fifo_geom_pkg::mem_addr_t addr;
      logic                     re;
   } mem_rd_t;

   // ------------------------------------------------------------
   // status
   // ------------------------------------------------------------

   // all fields registered in the level tracker
   // full and empty double as back-pressure for the two ports
   typedef struct packed {
      logic                  full;
      logic                  afull;
      logic                  empty;
      logic                  aempty;
      fifo_geom_pkg::level_t level;
   } fifo_status_t;

endpackage

//--- design/fifo_geom_pkg.sv
/*
 * Geometry of the synchronous FIFO controller.
 * Depth, address and level widths, and the static almost-full and
 * almost-empty thresholds. Referenced by scoped name from the RTL
 * and from the bus package.
 */

package fifo_geom_pkg;

   // ------------------------------------------------------------
   // depth and derived widths
   // ------------------------------------------------------------

   // number of entries in the external RAM
   localparam int FIFO_DEPTH = 16;

   // RAM address, 0 .. FIFO_DEPTH-1
   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   // occupancy must also hold FIFO_DEPTH itself, hence one extra bit
   localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

   // ------------------------------------------------------------
   // static flag thresholds
   // ------------------------------------------------------------

   // afull when level >= this
   localparam int AFULL_LEVEL = 14;

   // aempty when level <= this
   localparam int AEMPTY_LEVEL = 4;

   // ------------------------------------------------------------
   // typed widths
   // ------------------------------------------------------------

   // address into the external RAM
   typedef logic [ADDR_W-1:0] mem_addr_t;

   // occupancy count, 0 .. FIFO_DEPTH
   typedef logic [LEVEL_W-1:0] level_t;

endpackage
